// ==== Bender.yml ====
package:
  name: cache_top

sources:
  - aexm_cache_pkg.sv
  - sync_ram.sv
  - tlb_translate.sv
  - cache_lookup.sv
  - mem_refill.sv
  - cache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cache_top.sv

// ==== aexm_cache_pkg.sv ====
package aexm_cache_pkg;

  // -------------------
  // geometry
  // -------------------
  localparam int CACHE_IDX_W = 8;
  localparam int TLB_IDX_W   = 8;
  localparam int PTAG_W      = 22;
  localparam int VTAG_W      = 14;

  // -------------------
  // cpu side
  // -------------------
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
    logic        uncached;
    logic        vmem;
  } cpu_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        fault;
  } cpu_rsp_t;

  // tlb entry, both tags cover address bits 31..18
  typedef struct packed {
    logic [VTAG_W-1:0] vtag;
    logic [VTAG_W-1:0] ptag;
  } tlb_entry_t;

  typedef struct packed {
    logic [TLB_IDX_W-1:0] idx;
    tlb_entry_t           entry;
  } tlb_wr_t;

  // word addressed memory request
  typedef struct packed {
    logic [29:0] addr;
    logic [31:0] wdata;
    logic        we;
  } mem_req_t;

  typedef struct packed {
    logic              valid;
    logic [PTAG_W-1:0] ptag;
  } tag_entry_t;

  // -------------------
  // stage results
  // -------------------
  typedef struct packed {
    cpu_req_t    req;
    logic [31:0] paddr;
    logic        fault;
  } xlat_t;

  typedef struct packed {
    xlat_t       xlat;
    logic        hit;
    logic [31:0] data;
  } exec_t;

endpackage

// ==== cache_lookup.sv ====
module cache_lookup (
  input  logic                                      CPU_CLK,
  input  logic                                      RST,
  input  logic                                      req_valid,
  input  aexm_cache_pkg::cpu_req_t                   req,
  input  logic                                      xlat_valid,
  input  aexm_cache_pkg::xlat_t                      xlat,
  input  logic                                      fill_valid,
  input  logic [aexm_cache_pkg::CACHE_IDX_W-1:0]     fill_index,
  input  logic [31:0]                               fill_data,
  input  logic                                      tag_wr_valid,
  input  logic [aexm_cache_pkg::CACHE_IDX_W-2:0]     tag_wr_index,
  input  aexm_cache_pkg::tag_entry_t                 tag_wr,
  output logic                                      exec_valid,
  output aexm_cache_pkg::exec_t                      exec
);

  import aexm_cache_pkg::*;

  logic [31:0] data_rd;
  tag_entry_t  tag_rd;
  logic        hit;

  // -------------------
  // arrays, indexed virtually
  // -------------------
  sync_ram #(
    .T      (logic [31:0]),
    .ADDR_W (CACHE_IDX_W)
  ) u_data (
    .CPU_CLK (CPU_CLK),
    .re      (req_valid),
    .raddr   (req.addr[9:2]),
    .rdata   (data_rd),
    .we      (fill_valid),
    .waddr   (fill_index),
    .wdata   (fill_data)
  );

  // one tag per two word line
  sync_ram #(
    .T      (tag_entry_t),
    .ADDR_W (CACHE_IDX_W-1)
  ) u_tag (
    .CPU_CLK (CPU_CLK),
    .re      (req_valid),
    .raddr   (req.addr[9:3]),
    .rdata   (tag_rd),
    .we      (tag_wr_valid),
    .waddr   (tag_wr_index),
    .wdata   (tag_wr)
  );

  // physical tag compare
  assign hit = tag_rd.valid && (tag_rd.ptag == xlat.paddr[31:10])
               && !xlat.req.uncached && !xlat.fault;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      exec_valid <= 1'b0;
    end
    else
    begin
      exec_valid <= xlat_valid;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (xlat_valid)
    begin
      exec.xlat <= xlat;
      exec.hit  <= hit;
      exec.data <= data_rd;
    end
  end

  // array updates from the result stage must not overlap a compare
  a_no_fill_during_lookup: assert property (
    @(posedge CPU_CLK) disable iff (!RST)
    xlat_valid |-> !(fill_valid || tag_wr_valid));

endmodule

// ==== cache_top.f ====
+incdir+.
aexm_cache_pkg.sv
sync_ram.sv
tlb_translate.sv
cache_lookup.sv
mem_refill.sv
cache_top.sv
tb_cache_top.sv

// ==== cache_top.sv ====
module cache_top (
  input  logic                    CPU_CLK,
  input  logic                    RST,
  input  logic                    req_valid,
  input  aexm_cache_pkg::cpu_req_t req,
  input  logic                    tlb_wr_valid,
  input  aexm_cache_pkg::tlb_wr_t  tlb_wr,
  output logic                    busy,
  output logic                    rsp_valid,
  output aexm_cache_pkg::cpu_rsp_t rsp,
  output logic                    mem_req_valid,
  output aexm_cache_pkg::mem_req_t mem_req,
  input  logic                    mem_ack,
  input  logic [31:0]             mem_rdata
);

  import aexm_cache_pkg::*;

  logic                   xlat_valid;
  xlat_t                  xlat;
  logic                   exec_valid;
  exec_t                  exec;
  logic                   fill_valid;
  logic [CACHE_IDX_W-1:0] fill_index;
  logic [31:0]            fill_data;
  logic                   tag_wr_valid;
  logic [CACHE_IDX_W-2:0] tag_wr_index;
  tag_entry_t             tag_wr;

  // decode
  tlb_translate u_tlb_translate (
    .CPU_CLK      (CPU_CLK),
    .RST          (RST),
    .req_valid    (req_valid),
    .req          (req),
    .tlb_wr_valid (tlb_wr_valid),
    .tlb_wr       (tlb_wr),
    .busy         (busy),
    .xlat_valid   (xlat_valid),
    .xlat         (xlat)
  );

  // execute
  cache_lookup u_cache_lookup (
    .CPU_CLK      (CPU_CLK),
    .RST          (RST),
    .req_valid    (req_valid),
    .req          (req),
    .xlat_valid   (xlat_valid),
    .xlat         (xlat),
    .fill_valid   (fill_valid),
    .fill_index   (fill_index),
    .fill_data    (fill_data),
    .tag_wr_valid (tag_wr_valid),
    .tag_wr_index (tag_wr_index),
    .tag_wr       (tag_wr),
    .exec_valid   (exec_valid),
    .exec         (exec)
  );

  // result
  mem_refill u_mem_refill (
    .CPU_CLK       (CPU_CLK),
    .RST           (RST),
    .xlat_valid    (xlat_valid),
    .exec_valid    (exec_valid),
    .exec          (exec),
    .fill_valid    (fill_valid),
    .fill_index    (fill_index),
    .fill_data     (fill_data),
    .tag_wr_valid  (tag_wr_valid),
    .tag_wr_index  (tag_wr_index),
    .tag_wr        (tag_wr),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp),
    .busy          (busy)
  );

endmodule

// ==== mem_refill.sv ====
module mem_refill (
  input  logic                                      CPU_CLK,
  input  logic                                      RST,
  input  logic                                      xlat_valid,
  input  logic                                      exec_valid,
  input  aexm_cache_pkg::exec_t                      exec,
  output logic                                      fill_valid,
  output logic [aexm_cache_pkg::CACHE_IDX_W-1:0]     fill_index,
  output logic [31:0]                               fill_data,
  output logic                                      tag_wr_valid,
  output logic [aexm_cache_pkg::CACHE_IDX_W-2:0]     tag_wr_index,
  output aexm_cache_pkg::tag_entry_t                 tag_wr,
  output logic                                      mem_req_valid,
  output aexm_cache_pkg::mem_req_t                   mem_req,
  input  logic                                      mem_ack,
  input  logic [31:0]                               mem_rdata,
  output logic                                      rsp_valid,
  output aexm_cache_pkg::cpu_rsp_t                   rsp,
  output logic                                      busy
);

  import aexm_cache_pkg::*;

  typedef enum logic [2:0] {
    S_SWEEP,
    S_IDLE,
    S_REFILL,
    S_WRITE,
    S_UNC,
    S_RESP
  } state_t;

  state_t                 state;
  logic [CACHE_IDX_W-2:0] sweep_cnt;
  logic                   beat;
  logic                   busy_q;
  exec_t                  op;
  logic [31:0]            rdata_q;
  logic                   imm;
  logic                   start;
  logic                   ack;

  // faults and cached read hits answer without memory
  assign imm   = exec.xlat.fault
                 || (!exec.xlat.req.we && !exec.xlat.req.uncached && exec.hit);
  assign start = (state == S_IDLE) && exec_valid && !imm;
  assign ack   = mem_req_valid && mem_ack;

  // -------------------
  // control
  // -------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state         <= S_SWEEP;
      sweep_cnt     <= '0;
      beat          <= 1'b0;
      busy_q        <= 1'b0;
      mem_req_valid <= 1'b0;
    end
    else
    begin
      case (state)
        S_SWEEP:
        begin
          sweep_cnt <= sweep_cnt + 1'b1;
          busy_q    <= !(&sweep_cnt);
          if (&sweep_cnt)
          begin
            state <= S_IDLE;
          end
        end
        S_IDLE:
        begin
          busy_q <= start;
          if (start)
          begin
            mem_req_valid <= 1'b1;
            beat          <= 1'b0;
            if (exec.xlat.req.we)
              state <= S_WRITE;
            else if (exec.xlat.req.uncached)
              state <= S_UNC;
            else
              state <= S_REFILL;
          end
        end
        S_REFILL:
        begin
          if (ack)
          begin
            mem_req_valid <= 1'b0;
            beat          <= 1'b1;
            if (beat)
            begin
              busy_q <= 1'b0;
              state  <= S_RESP;
            end
          end
          else if (!mem_req_valid)
          begin
            // line partner goes out one cycle after the first ack
            mem_req_valid <= 1'b1;
          end
        end
        S_WRITE, S_UNC:
        begin
          if (ack)
          begin
            mem_req_valid <= 1'b0;
            busy_q        <= 1'b0;
            state         <= S_RESP;
          end
        end
        S_RESP:
        begin
          state <= S_IDLE;
        end
        default:
        begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // -------------------
  // payload
  // -------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (start)
    begin
      op            <= exec;
      mem_req.addr  <= exec.xlat.paddr[31:2];
      mem_req.wdata <= exec.xlat.req.wdata;
      mem_req.we    <= exec.xlat.req.we;
    end
    else if (ack && (state == S_REFILL) && !beat)
    begin
      mem_req.addr[0] <= ~mem_req.addr[0];
    end
    // requested word is always the first one back
    if (ack && (((state == S_REFILL) && !beat) || (state == S_UNC)))
    begin
      rdata_q <= mem_rdata;
    end
  end

  // refill words, and write-through hits
  assign fill_valid = ack && ((state == S_REFILL) || ((state == S_WRITE) && op.hit));
  assign fill_index = mem_req.addr[CACHE_IDX_W-1:0];
  assign fill_data  = (state == S_WRITE) ? mem_req.wdata : mem_rdata;

  // tag goes in with the second refill word
  assign tag_wr_valid = (state == S_SWEEP) || (ack && (state == S_REFILL) && beat);
  assign tag_wr_index = (state == S_SWEEP) ? sweep_cnt : mem_req.addr[CACHE_IDX_W-1:1];
  assign tag_wr.valid = (state != S_SWEEP);
  assign tag_wr.ptag  = op.xlat.paddr[31:10];

  // -------------------
  // response
  // -------------------
  assign rsp_valid = (state == S_RESP) || ((state == S_IDLE) && exec_valid && imm);

  always_comb
  begin
    if (state == S_RESP)
    begin
      rsp.rdata = rdata_q;
      rsp.fault = 1'b0;
    end
    else
    begin
      rsp.rdata = exec.xlat.fault ? '0 : exec.data;
      rsp.fault = exec.xlat.fault;
    end
  end

  // covers the two cycles before the request reaches this stage
  assign busy = busy_q || xlat_valid || (exec_valid && !rsp_valid);

  a_mem_req_stable: assert property (
    @(posedge CPU_CLK) disable iff (!RST)
    (mem_req_valid && !mem_ack) |=> (mem_req_valid && $stable(mem_req)));

endmodule

// ==== sync_ram.sv ====
module sync_ram #(
  parameter type T      = logic [31:0],
  parameter int  ADDR_W = 8
) (
  input  logic              CPU_CLK,
  input  logic              re,
  input  logic [ADDR_W-1:0] raddr,
  output T                  rdata,
  input  logic              we,
  input  logic [ADDR_W-1:0] waddr,
  input  T                  wdata
);

  T mem [2**ADDR_W];

  // read and write on the same edge return the old word
  always_ff @(posedge CPU_CLK)
  begin
    if (we)
    begin
      mem[waddr] <= wdata;
    end
    if (re)
    begin
      rdata <= mem[raddr];
    end
  end

endmodule

// ==== tb_cache_tasks.svh ====
  // --------------------
  // failure and compares
  // --------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_rsp(input string name, input cpu_rsp_t got, input cpu_rsp_t exp);
    if (got !== exp)
      abort_run($sformatf("error at %0t: %s expected %h got %h", $time, name, exp, got));
  endtask

  task automatic check_mem_req(input string name, input mem_req_t got, input mem_req_t exp);
    if (got !== exp)
      abort_run($sformatf("error at %0t: %s expected %h got %h", $time, name, exp, got));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("error at %0t: %s expected %b got %b", $time, name, exp, got));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
      abort_run($sformatf("error at %0t: %s expected %0d got %0d", $time, name, exp, got));
  endtask

  // --------------------
  // cpu side
  // --------------------
  function automatic cpu_req_t make_req(input logic [31:0] addr, input logic [31:0] wdata,
                                        input logic we, input logic uncached,
                                        input logic vmem);
    cpu_req_t r;
    r.addr     = addr;
    r.wdata    = wdata;
    r.we       = we;
    r.uncached = uncached;
    r.vmem     = vmem;
    return r;
  endfunction

  task automatic wait_idle();
    @(negedge CPU_CLK);
    while (busy)
      @(negedge CPU_CLK);
  endtask

  // latency counts falling edges from the strobe to rsp_valid
  task automatic issue_request(input cpu_req_t r, output cpu_rsp_t got, output int lat);
    wait_idle();
    req       = r;
    req_valid = 1'b1;
    @(negedge CPU_CLK);
    req_valid = 1'b0;
    req       = '0;
    lat       = 1;
    while (!rsp_valid)
    begin
      @(negedge CPU_CLK);
      lat++;
    end
    got = rsp;
  endtask

  task automatic write_tlb(input logic [7:0] idx, input tlb_entry_t e);
    wait_idle();
    tlb_wr.idx   = idx;
    tlb_wr.entry = e;
    tlb_wr_valid = 1'b1;
    @(negedge CPU_CLK);
    tlb_wr_valid = 1'b0;
  endtask

  // --------------------
  // expected responses
  // --------------------
  task automatic expect_hit(input logic [31:0] addr, input logic [31:0] data);
    cpu_rsp_t got;
    cpu_rsp_t exp_rsp;
    int       lat;
    int       base;
    base = mem_log.size();
    issue_request(make_req(addr, '0, 1'b0, 1'b0, 1'b0), got, lat);
    check_count("hit latency", lat, 2);
    exp_rsp.rdata = data;
    exp_rsp.fault = 1'b0;
    check_rsp("rsp", got, exp_rsp);
    check_count("memory transactions", mem_log.size() - base, 0);
    // no memory access may follow the answer
    @(negedge CPU_CLK);
    check_bit("mem_req_valid", mem_req_valid, 1'b0);
  endtask

  // requested word first, then its line partner
  task automatic expect_refill(input cpu_req_t r, input logic [29:0] waddr);
    cpu_rsp_t got;
    cpu_rsp_t exp_rsp;
    mem_req_t exp_req;
    int       lat;
    int       base;
    base = mem_log.size();
    issue_request(r, got, lat);
    check_count("memory transactions", mem_log.size() - base, 2);
    exp_req.addr  = waddr;
    exp_req.wdata = '0;
    exp_req.we    = 1'b0;
    check_mem_req("first mem_req", mem_log[base], exp_req);
    exp_req.addr = {waddr[29:1], ~waddr[0]};
    check_mem_req("second mem_req", mem_log[base+1], exp_req);
    exp_rsp.rdata = model_word(waddr);
    exp_rsp.fault = 1'b0;
    check_rsp("rsp", got, exp_rsp);
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    cpu_rsp_t got;
    mem_req_t exp_req;
    int       lat;
    int       base;
    base = mem_log.size();
    issue_request(make_req(addr, data, 1'b1, 1'b0, 1'b0), got, lat);
    check_count("memory transactions", mem_log.size() - base, 1);
    exp_req.addr  = addr[31:2];
    exp_req.wdata = data;
    exp_req.we    = 1'b1;
    check_mem_req("write mem_req", mem_log[base], exp_req);
    check_bit("rsp.fault", got.fault, 1'b0);
  endtask

  task automatic uncached_read(input logic [31:0] addr);
    cpu_rsp_t got;
    cpu_rsp_t exp_rsp;
    mem_req_t exp_req;
    int       lat;
    int       base;
    base = mem_log.size();
    issue_request(make_req(addr, '0, 1'b0, 1'b1, 1'b0), got, lat);
    check_count("memory transactions", mem_log.size() - base, 1);
    exp_req.addr  = addr[31:2];
    exp_req.wdata = '0;
    exp_req.we    = 1'b0;
    check_mem_req("uncached mem_req", mem_log[base], exp_req);
    exp_rsp.rdata = model_word(addr[31:2]);
    exp_rsp.fault = 1'b0;
    check_rsp("rsp", got, exp_rsp);
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic reset_and_sweep();
    int n;
    @(negedge CPU_CLK);
    check_bit("busy", busy, 1'b0);
    check_bit("rsp_valid", rsp_valid, 1'b0);
    check_bit("mem_req_valid", mem_req_valid, 1'b0);
    RST = 1'b1;
    @(negedge CPU_CLK);
    check_bit("busy", busy, 1'b1);
    n = 0;
    while (busy)
    begin
      n++;
      @(negedge CPU_CLK);
    end
    // one tag line per cycle
    if (n < 126 || n > 130)
      abort_run($sformatf("busy stayed high for %0d cycles of the tag sweep", n));
    check_bit("mem_req_valid", mem_req_valid, 1'b0);
  endtask

  task automatic miss_then_hit();
    logic [31:0] a;
    a = 32'h0000_2a4c;
    expect_refill(make_req(a, '0, 1'b0, 1'b0, 1'b0), a[31:2]);
    expect_hit(a, model_word(a[31:2]));
    expect_hit(a ^ 32'h4, model_word(a[31:2] ^ 30'h1));
  endtask

  task automatic write_through();
    logic [31:0] a;
    logic [31:0] b;
    a = 32'h0000_2a4c;
    write_word(a, 32'hfeed_0123);
    expect_hit(a, 32'hfeed_0123);
    // same index, other tag, cached word untouched
    write_word(a ^ 32'h400, 32'h1357_9bdf);
    expect_hit(a, 32'hfeed_0123);
    // no allocate on a write miss
    b = 32'h0000_3100;
    write_word(b, 32'h0bad_cafe);
    expect_refill(make_req(b, '0, 1'b0, 1'b0, 1'b0), b[31:2]);
  endtask

  task automatic uncached_reads();
    logic [31:0] c;
    c = 32'h0000_0510;
    uncached_read(c);
    uncached_read(c);
    expect_refill(make_req(c, '0, 1'b0, 1'b0, 1'b0), c[31:2]);
    // line now cached, still goes to memory
    uncached_read(c);
  endtask

  task automatic tlb_translation();
    tlb_entry_t  e;
    logic [31:0] va;
    logic [31:0] bad;
    cpu_rsp_t    got;
    cpu_rsp_t    exp_rsp;
    int          lat;
    int          base;
    e.vtag = 14'h0123;
    e.ptag = 14'h02a7;
    write_tlb(8'h5c, e);
    va = {e.vtag, 8'h5c, 10'h1f4};
    expect_refill(make_req(va, '0, 1'b0, 1'b0, 1'b1), {e.ptag, va[17:2]});
    // wrong virtual tag at the same entry
    bad  = {e.vtag ^ 14'h0040, 8'h5c, 10'h1f4};
    base = mem_log.size();
    issue_request(make_req(bad, '0, 1'b0, 1'b0, 1'b1), got, lat);
    check_count("fault latency", lat, 2);
    exp_rsp.rdata = '0;
    exp_rsp.fault = 1'b1;
    check_rsp("rsp", got, exp_rsp);
    @(negedge CPU_CLK);
    check_bit("mem_req_valid", mem_req_valid, 1'b0);
    check_count("memory transactions", mem_log.size() - base, 0);
  endtask

// ==== tb_cache_top.sv ====
module tb_cache_top;

  import aexm_cache_pkg::*;

  // reset and sweep take about 140 cycles, about 20 requests at 16 worst case
  localparam int CYCLE_LIMIT = 4000;

  logic        CPU_CLK;
  logic        RST;
  logic        req_valid;
  cpu_req_t    req;
  logic        tlb_wr_valid;
  tlb_wr_t     tlb_wr;
  logic        busy;
  logic        rsp_valid;
  cpu_rsp_t    rsp;
  logic        mem_req_valid;
  mem_req_t    mem_req;
  logic        mem_ack;
  logic [31:0] mem_rdata;

  int          cycle_count;
  logic [31:0] mem_words [logic [29:0]];
  mem_req_t    mem_log [$];

  cache_top dut (
    .CPU_CLK       (CPU_CLK),
    .RST           (RST),
    .req_valid     (req_valid),
    .req           (req),
    .tlb_wr_valid  (tlb_wr_valid),
    .tlb_wr        (tlb_wr),
    .busy          (busy),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata)
  );

  initial
  begin
    CPU_CLK = 1'b0;
    forever #20 CPU_CLK = ~CPU_CLK;
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT)
    begin
      @(posedge CPU_CLK);
      cycle_count++;
    end
    $display("run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("SOME TESTS FAILED");
    $fatal(1, "timeout");
  end

  // --------------------
  // memory model
  // --------------------
  // unwritten words come from the full word address
  function automatic logic [31:0] model_word(input logic [29:0] waddr);
    if (mem_words.exists(waddr))
      return mem_words[waddr];
    return {waddr[13:0], waddr[29:12]} ^ 32'hc1bb_0f0f;
  endfunction

  initial
  begin
    int wait_left;
    void'($urandom(32'hc1bb));
    wait_left = 0;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    forever
    begin
      @(negedge CPU_CLK);
      if (mem_ack)
      begin
        mem_ack   = 1'b0;
        mem_rdata = '0;
      end
      else if (mem_req_valid)
      begin
        // 1 to 4 cycles until ack
        if (wait_left == 0)
          wait_left = $urandom % 4 + 1;
        wait_left--;
        if (wait_left == 0)
        begin
          mem_log.push_back(mem_req);
          if (mem_req.we)
            mem_words[mem_req.addr] = mem_req.wdata;
          else
            mem_rdata = model_word(mem_req.addr);
          mem_ack = 1'b1;
        end
      end
    end
  end

  `include "tb_cache_tasks.svh"

  initial
  begin
    RST          = 1'b0;
    req_valid    = 1'b0;
    req          = '0;
    tlb_wr_valid = 1'b0;
    tlb_wr       = '0;
    repeat (8) @(posedge CPU_CLK);
    reset_and_sweep();
    miss_then_hit();
    write_through();
    uncached_reads();
    tlb_translation();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== tlb_translate.sv ====
module tlb_translate (
  input  logic                    CPU_CLK,
  input  logic                    RST,
  input  logic                    req_valid,
  input  aexm_cache_pkg::cpu_req_t req,
  input  logic                    tlb_wr_valid,
  input  aexm_cache_pkg::tlb_wr_t  tlb_wr,
  input  logic                    busy,
  output logic                    xlat_valid,
  output aexm_cache_pkg::xlat_t    xlat
);

  import aexm_cache_pkg::*;

  cpu_req_t   req_q;
  tlb_entry_t tlb_rd;

  // -------------------
  // tlb array
  // -------------------
  sync_ram #(
    .T      (tlb_entry_t),
    .ADDR_W (TLB_IDX_W)
  ) u_tlb (
    .CPU_CLK (CPU_CLK),
    .re      (req_valid),
    .raddr   (req.addr[17:10]),
    .rdata   (tlb_rd),
    .we      (tlb_wr_valid),
    .waddr   (tlb_wr.idx),
    .wdata   (tlb_wr.entry)
  );

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      xlat_valid <= 1'b0;
    end
    else
    begin
      xlat_valid <= req_valid;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (req_valid)
    begin
      req_q <= req;
    end
  end

  // physical address from the entry read last edge
  always_comb
  begin
    xlat.req = req_q;
    if (req_q.vmem)
    begin
      xlat.paddr = {tlb_rd.ptag, req_q.addr[17:0]};
      xlat.fault = (tlb_rd.vtag != req_q.addr[31:18]);
    end
    else
    begin
      xlat.paddr = req_q.addr;
      xlat.fault = 1'b0;
    end
  end

  // -------------------
  // cpu strobe rules
  // -------------------
  // busy comes back from the result stage
  a_no_req_when_busy: assert property (
    @(posedge CPU_CLK) disable iff (!RST) req_valid |-> !busy);

  a_no_req_with_tlb_wr: assert property (
    @(posedge CPU_CLK) disable iff (!RST) !(req_valid && tlb_wr_valid));

endmodule
